// ==== design/vis_pkg.sv ====
// ==========================================================================
// Shared sizes, vector types and structs of the vector issue stage
// Imported by every module of the issue stage and by its testbench
// ==========================================================================
`default_nettype none

package vis_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int N_VREGS    = 32;
    localparam int N_LANES    = 8;
    localparam int DATA_W     = 32;
    localparam int TICKET_W   = 4;
    localparam int LANE_SHIFT = $clog2(N_LANES);

    // ======================================================================
    // Vector typedefs
    // ======================================================================
    typedef logic [$clog2(N_VREGS)-1:0]         vreg_addr_t;
    typedef logic [TICKET_W-1:0]                ticket_t;
    typedef logic [DATA_W-1:0]                  elem_t;
    typedef logic [N_LANES-1:0]                 lane_mask_t;
    // Up to N_VREGS * N_LANES elements, so one extra bit
    typedef logic [$clog2(N_VREGS*N_LANES):0]   vl_t;
    typedef logic [1:0]                         fu_t;
    typedef logic [6:0]                         microop_t;

    // ======================================================================
    // Structs
    // ======================================================================
    typedef struct packed {
        vreg_addr_t dst;
        vreg_addr_t src1;
        vreg_addr_t src2;
        logic       dst_iszero;
        logic       src1_iszero;
        logic       src2_iszero;
        fu_t        fu;
        microop_t   microop;
        ticket_t    ticket;
        vl_t        vl;
        elem_t      immediate;
    } vis_instr_t;

    typedef struct packed {
        fu_t        fu;
        microop_t   microop;
        ticket_t    ticket;
        vreg_addr_t dst;
        logic       head_uop;
        logic       end_uop;
        vl_t        vl;
    } exec_info_t;

    typedef struct packed {
        logic  valid;
        elem_t data1;
        elem_t data2;
        elem_t immediate;
    } exec_lane_t;

    typedef struct packed {
        lane_mask_t en;
        vreg_addr_t addr;
        ticket_t    ticket;
    } wb_port_t;

    // Current micro-op as the datapath sees it
    typedef struct packed {
        vreg_addr_t src1;
        vreg_addr_t src2;
        vreg_addr_t dst;
        logic       src1_iszero;
        logic       src2_iszero;
        lane_mask_t lane_valid;
    } uop_ctx_t;

endpackage

`default_nettype wire

// ==== design/issue_ctrl.sv ====
// ==========================================================================
// Expansion controller, walks one instruction through its micro-ops
// Decides issue and pop, and drives the micro-op context to the datapath
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl
    import vis_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         valid_i,
    input  vis_instr_t  instr_i,
    input  wire         ready_i,
    input  lane_mask_t  operands_ok_i,
    output uop_ctx_t    ctx_o,
    output logic        issue_o,
    output logic        ready_o,
    output logic        valid_o,
    output exec_info_t  info_o
);

    vreg_addr_t exp_cnt;
    vl_t        remaining;
    lane_mask_t lane_valid;
    logic       head_uop;
    logic       end_uop;
    logic       vl_reached;
    logic       last_reg;
    logic       pop;

    // One bit wider than vl_t so (count + 1) * lanes never wraps
    logic [$bits(vl_t):0] next_base;

    // ======================================================================
    // Expansion bookkeeping
    // ======================================================================
    assign remaining  = instr_i.vl - (vl_t'(exp_cnt) << LANE_SHIFT);
    assign next_base  = ({1'b0, vl_t'(exp_cnt)} + 1'b1) << LANE_SHIFT;
    assign vl_reached = next_base >= {1'b0, instr_i.vl};
    assign last_reg   = exp_cnt == vreg_addr_t'(N_VREGS - 1);
    assign end_uop    = vl_reached | last_reg;
    assign head_uop   = exp_cnt == '0;

    // Thermometer of lanes still inside vl
    always_comb begin
        for (int k = 0; k < N_LANES; k++) begin
            lane_valid[k] = remaining > vl_t'(k);
        end
    end

    // Register indices advance by one per micro-op, wrapping at N_VREGS
    always_comb begin
        ctx_o.src1        = instr_i.src1 + exp_cnt;
        ctx_o.src2        = instr_i.src2 + exp_cnt;
        ctx_o.dst         = instr_i.dst + exp_cnt;
        ctx_o.src1_iszero = instr_i.src1_iszero;
        ctx_o.src2_iszero = instr_i.src2_iszero;
        ctx_o.lane_valid  = lane_valid;
    end

    // ======================================================================
    // Issue and pop
    // ======================================================================
    // Inactive lanes never hold up the micro-op
    assign issue_o = valid_i & ready_i & (&(operands_ok_i | ~lane_valid));
    assign ready_o = issue_o & end_uop;
    assign valid_o = issue_o;
    assign pop     = valid_i & ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_cnt <= '0;
        end else if (pop) begin
            exp_cnt <= '0;
        end else if (issue_o) begin
            exp_cnt <= exp_cnt + 1'b1;
        end
    end

    // ======================================================================
    // Control towards execution
    // ======================================================================
    always_comb begin
        info_o.fu       = instr_i.fu;
        info_o.microop  = instr_i.microop;
        info_o.ticket   = instr_i.ticket;
        info_o.dst      = ctx_o.dst;
        info_o.head_uop = head_uop;
        info_o.end_uop  = end_uop;
        // Full length on the head, what is left on the rest
        info_o.vl       = head_uop ? instr_i.vl : remaining;
    end

endmodule

`default_nettype wire

// ==== design/pending_scoreboard.sv ====
// ==========================================================================
// Per-register, per-lane pending bits with the writer's ticket
// Set by issue of a writer, cleared by a writeback with a matching ticket
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module pending_scoreboard
    import vis_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         issue_i,
    input  uop_ctx_t    ctx_i,
    input  wire         dst_iszero_i,
    input  ticket_t     ticket_i,
    input  wb_port_t    wb_i,
    output lane_mask_t  src1_pending_o,
    output lane_mask_t  src2_pending_o,
    output ticket_t     src1_ticket_o,
    output ticket_t     src2_ticket_o,
    output logic        idle_o
);

    lane_mask_t [N_VREGS-1:0] pending_q;
    ticket_t    [N_VREGS-1:0] ticket_q;

    logic set_dst;
    logic wb_match;

    // A zero destination never becomes a hazard
    assign set_dst  = issue_i & ~dst_iszero_i;

    // Only the latest writer of a register may release it
    assign wb_match = wb_i.ticket == ticket_q[wb_i.addr];

    // ======================================================================
    // Pending state update
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
            ticket_q  <= '0;
        end else begin
            for (int r = 0; r < N_VREGS; r++) begin
                if (set_dst && ctx_i.dst == vreg_addr_t'(r)) begin
                    // Active lanes become pending, lanes beyond vl are free
                    pending_q[r] <= ctx_i.lane_valid;
                    ticket_q[r]  <= ticket_i;
                end else if (wb_match && wb_i.addr == vreg_addr_t'(r)) begin
                    pending_q[r] <= pending_q[r] & ~wb_i.en;
                end
            end
        end
    end

    // ======================================================================
    // Source lookup
    // ======================================================================
    assign src1_pending_o = pending_q[ctx_i.src1];
    assign src2_pending_o = pending_q[ctx_i.src2];
    assign src1_ticket_o  = ticket_q[ctx_i.src1];
    assign src2_ticket_o  = ticket_q[ctx_i.src2];

    assign idle_o = ~|pending_q;

endmodule

`default_nettype wire

// ==== design/operand_select.sv ====
// ==========================================================================
// Operand hazard check and forwarding from the writeback port
// Builds the per-lane payload towards execution
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module operand_select
    import vis_pkg::*;
(
    input  uop_ctx_t                    ctx_i,
    input  lane_mask_t                  src1_pending_i,
    input  lane_mask_t                  src2_pending_i,
    input  ticket_t                     src1_ticket_i,
    input  ticket_t                     src2_ticket_i,
    input  wb_port_t                    wb_i,
    input  elem_t [N_LANES-1:0]         wb_data_i,
    input  elem_t [N_LANES-1:0]         rd_data1_i,
    input  elem_t [N_LANES-1:0]         rd_data2_i,
    input  elem_t                       immediate_i,
    output exec_lane_t [N_LANES-1:0]    lanes_o,
    output lane_mask_t                  operands_ok_o
);

    lane_mask_t fwd1;
    lane_mask_t fwd2;
    lane_mask_t src1_ok;
    lane_mask_t src2_ok;

    // Writeback lanes that carry the value a source is waiting for
    function automatic lane_mask_t fwd_match(input wb_port_t wb, input vreg_addr_t src,
                                             input ticket_t tkt);
        lane_mask_t hit;
        hit = (wb.addr == src && wb.ticket == tkt) ? wb.en : '0;
        return hit;
    endfunction

    assign fwd1 = fwd_match(wb_i, ctx_i.src1, src1_ticket_i);
    assign fwd2 = fwd_match(wb_i, ctx_i.src2, src2_ticket_i);

    assign src1_ok = {N_LANES{ctx_i.src1_iszero}} | fwd1 | ~src1_pending_i;
    assign src2_ok = {N_LANES{ctx_i.src2_iszero}} | fwd2 | ~src2_pending_i;

    assign operands_ok_o = src1_ok & src2_ok;

    // ======================================================================
    // Lane payload
    // ======================================================================
    always_comb begin
        for (int k = 0; k < N_LANES; k++) begin
            lanes_o[k].valid     = ctx_i.lane_valid[k];
            lanes_o[k].data1     = fwd1[k] ? wb_data_i[k] : rd_data1_i[k];
            lanes_o[k].data2     = fwd2[k] ? wb_data_i[k] : rd_data2_i[k];
            lanes_o[k].immediate = immediate_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/vector_regfile.sv ====
// ==========================================================================
// Vector register file, registers by lanes by elements
// Two asynchronous whole-register reads, one per-lane enabled write
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module vector_regfile
    import vis_pkg::*;
(
    input  wire                     clk,
    // Read ports
    input  vreg_addr_t              rd_addr1_i,
    input  vreg_addr_t              rd_addr2_i,
    output elem_t [N_LANES-1:0]     rd_data1_o,
    output elem_t [N_LANES-1:0]     rd_data2_o,
    // Writeback port
    input  wb_port_t                wb_i,
    input  elem_t [N_LANES-1:0]     wb_data_i
);

    // ======================================================================
    // Storage
    // ======================================================================
    elem_t [N_LANES-1:0] mem [N_VREGS];

    // Written lanes of a register only, others keep their value
    always_ff @(posedge clk) begin
        for (int k = 0; k < N_LANES; k++) begin
            if (wb_i.en[k]) begin
                mem[wb_i.addr][k] <= wb_data_i[k];
            end
        end
    end

    // ======================================================================
    // Read ports
    // ======================================================================
    // Same-cycle writeback data reaches the reader through forwarding
    assign rd_data1_o = mem[rd_addr1_i];
    assign rd_data2_o = mem[rd_addr2_i];

endmodule

`default_nettype wire

// ==== design/vis_top.sv ====
// ==========================================================================
// Vector issue stage top level, expands one instruction into micro-ops
// Connects the controller, scoreboard, operand selector and register file
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module vis_top
    import vis_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    // Instruction side
    input  wire                         valid_i,
    input  vis_instr_t                  instr_i,
    output logic                        ready_o,
    // Execution side
    output logic                        valid_o,
    output exec_info_t                  info_o,
    output exec_lane_t [N_LANES-1:0]    lanes_o,
    input  wire                         ready_i,
    // Writeback side
    input  wb_port_t                    wb_i,
    input  elem_t [N_LANES-1:0]         wb_data_i,
    output logic                        idle_o
);

    uop_ctx_t   ctx;
    logic       issue;
    lane_mask_t operands_ok;
    lane_mask_t src1_pending;
    lane_mask_t src2_pending;
    ticket_t    src1_ticket;
    ticket_t    src2_ticket;
    logic       sb_idle;

    elem_t [N_LANES-1:0] rd_data1;
    elem_t [N_LANES-1:0] rd_data2;

    issue_ctrl u_issue_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_i       (valid_i),
        .instr_i       (instr_i),
        .ready_i       (ready_i),
        .operands_ok_i (operands_ok),
        .ctx_o         (ctx),
        .issue_o       (issue),
        .ready_o       (ready_o),
        .valid_o       (valid_o),
        .info_o        (info_o)
    );

    pending_scoreboard u_scoreboard (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_i        (issue),
        .ctx_i          (ctx),
        .dst_iszero_i   (instr_i.dst_iszero),
        .ticket_i       (instr_i.ticket),
        .wb_i           (wb_i),
        .src1_pending_o (src1_pending),
        .src2_pending_o (src2_pending),
        .src1_ticket_o  (src1_ticket),
        .src2_ticket_o  (src2_ticket),
        .idle_o         (sb_idle)
    );

    operand_select u_operand_select (
        .ctx_i          (ctx),
        .src1_pending_i (src1_pending),
        .src2_pending_i (src2_pending),
        .src1_ticket_i  (src1_ticket),
        .src2_ticket_i  (src2_ticket),
        .wb_i           (wb_i),
        .wb_data_i      (wb_data_i),
        .rd_data1_i     (rd_data1),
        .rd_data2_i     (rd_data2),
        .immediate_i    (instr_i.immediate),
        .lanes_o        (lanes_o),
        .operands_ok_o  (operands_ok)
    );

    vector_regfile u_regfile (
        .clk        (clk),
        .rd_addr1_i (ctx.src1),
        .rd_addr2_i (ctx.src2),
        .rd_data1_o (rd_data1),
        .rd_data2_o (rd_data2),
        .wb_i       (wb_i),
        .wb_data_i  (wb_data_i)
    );

    // Nothing waiting at the input and no writer in flight
    assign idle_o = ~valid_i & sb_idle;

endmodule

`default_nettype wire

// ==== tests/vis_chk.sv ====
// ==========================================================================
// Protocol assertions on the issue stage top level, bound into vis_top
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module vis_chk
    import vis_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire         valid_o,
    input  wire         ready_o,
    input  wire         ready_i,
    input  exec_info_t  info_o
);

    // Set after a non-final micro-op, cleared by the pop
    logic mid_instr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_instr <= 1'b0;
        end else if (ready_o) begin
            mid_instr <= 1'b0;
        end else if (valid_o) begin
            mid_instr <= 1'b1;
        end
    end

    // Micro-ops only leave into a ready execution side
    a_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> ready_i)
        else $error("valid_o high while ready_i is low");

    a_pop_on_end: assert property (@(posedge clk) disable iff (!rst_n)
        ready_o |-> info_o.end_uop)
        else $error("ready_o high without end_uop");

    a_single_head: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_o && mid_instr) |-> !info_o.head_uop)
        else $error("head_uop repeated within one instruction");

endmodule

bind vis_top vis_chk u_chk (
    .clk     (clk),
    .rst_n   (rst_n),
    .valid_o (valid_o),
    .ready_o (ready_o),
    .ready_i (ready_i),
    .info_o  (info_o)
);

`default_nettype wire

// ==== tests/vis_tb.sv ====
// ==========================================================================
// Testbench of the vector issue stage, a table of steps applied in a loop
// A model of the register file and pending state predicts every result
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module vis_tb
    import vis_pkg::*;
();

    localparam int TIMEOUT = 40;

    typedef struct packed {
        logic       is_wb;
        vis_instr_t instr;
        wb_port_t   wb;
        logic [5:0] n_uops;
        logic       stall;
        logic       idle;
    } step_t;

    logic                       clk;
    logic                       rst_n;
    logic                       valid_i;
    vis_instr_t                 instr_i;
    logic                       ready_o;
    logic                       valid_o;
    exec_info_t                 info_o;
    exec_lane_t [N_LANES-1:0]   lanes_o;
    logic                       ready_i;
    wb_port_t                   wb_i;
    elem_t [N_LANES-1:0]        wb_data_i;
    logic                       idle_o;

    // Reference model of the register file and the scoreboard
    elem_t [N_LANES-1:0] model_rf [N_VREGS];
    lane_mask_t          model_pend [N_VREGS];
    ticket_t             model_tkt [N_VREGS];

    step_t      steps [$];
    step_t      s;
    vis_instr_t held;

    vis_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_i   (valid_i),
        .instr_i   (instr_i),
        .ready_o   (ready_o),
        .valid_o   (valid_o),
        .info_o    (info_o),
        .lanes_o   (lanes_o),
        .ready_i   (ready_i),
        .wb_i      (wb_i),
        .wb_data_i (wb_data_i),
        .idle_o    (idle_o)
    );

    always #2 clk = ~clk;

    // ======================================================================
    // Error reporting and compare tasks
    // ======================================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_info(input string name, input exec_info_t got, input exec_info_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_lane(input string name, input exec_lane_t got, input exec_lane_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // ======================================================================
    // Expected values
    // ======================================================================
    function automatic lane_mask_t active_lanes(input vis_instr_t ins, input int u);
        lane_mask_t m;
        for (int k = 0; k < N_LANES; k++) begin
            m[k] = (int'(ins.vl) - u * N_LANES) > k;
        end
        return m;
    endfunction

    function automatic exec_info_t expect_info(input vis_instr_t ins, input int u);
        exec_info_t e;
        e.fu       = ins.fu;
        e.microop  = ins.microop;
        e.ticket   = ins.ticket;
        e.dst      = ins.dst + vreg_addr_t'(u);
        e.head_uop = u == 0;
        e.end_uop  = ((u + 1) * N_LANES >= int'(ins.vl)) || (u == N_VREGS - 1);
        e.vl       = (u == 0) ? ins.vl : vl_t'(int'(ins.vl) - u * N_LANES);
        return e;
    endfunction

    // Writeback lane carrying the value the source waits for
    function automatic logic fwd_hit(input vreg_addr_t src, input int k);
        return wb_i.en[k] && wb_i.addr == src && wb_i.ticket == model_tkt[src];
    endfunction

    function automatic exec_lane_t expect_lane(input vis_instr_t ins, input int u, input int k);
        exec_lane_t e;
        lane_mask_t m;
        vreg_addr_t a1;
        vreg_addr_t a2;
        m           = active_lanes(ins, u);
        a1          = ins.src1 + vreg_addr_t'(u);
        a2          = ins.src2 + vreg_addr_t'(u);
        e.valid     = m[k];
        e.data1     = fwd_hit(a1, k) ? wb_data_i[k] : model_rf[a1][k];
        e.data2     = fwd_hit(a2, k) ? wb_data_i[k] : model_rf[a2][k];
        e.immediate = ins.immediate;
        return e;
    endfunction

    // Issue predicted from the model's pending state
    function automatic logic model_ready(input vis_instr_t ins, input int u);
        lane_mask_t m;
        vreg_addr_t a1;
        vreg_addr_t a2;
        logic       ok;
        m  = active_lanes(ins, u);
        a1 = ins.src1 + vreg_addr_t'(u);
        a2 = ins.src2 + vreg_addr_t'(u);
        ok = valid_i && ready_i;
        for (int k = 0; k < N_LANES; k++) begin
            if (m[k] && !(ins.src1_iszero || fwd_hit(a1, k) || !model_pend[a1][k])) begin
                ok = 1'b0;
            end
            if (m[k] && !(ins.src2_iszero || fwd_hit(a2, k) || !model_pend[a2][k])) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // ======================================================================
    // Cycle tasks
    // ======================================================================
    // Model update for the ending cycle, then on to the next drive point
    task automatic advance(input logic issued, input vis_instr_t ins, input int u);
        vreg_addr_t d;
        d = ins.dst + vreg_addr_t'(u);
        if (wb_i.ticket == model_tkt[wb_i.addr]) begin
            model_pend[wb_i.addr] = model_pend[wb_i.addr] & ~wb_i.en;
        end
        if (issued && !ins.dst_iszero) begin
            model_pend[d] = active_lanes(ins, u);
            model_tkt[d]  = ins.ticket;
        end
        for (int k = 0; k < N_LANES; k++) begin
            if (wb_i.en[k]) begin
                model_rf[wb_i.addr][k] = wb_data_i[k];
            end
        end
        @(posedge clk);
        #1;
        wb_i.en = '0;
    endtask

    task automatic sample_cycle(input vis_instr_t ins, input int u, output logic issued);
        @(negedge clk);
        issued = valid_o;
        check_bit("valid_o", valid_o, model_ready(ins, u));
        if (!issued) begin
            check_bit("ready_o", ready_o, 1'b0);
        end
    endtask

    task automatic run_uops(input vis_instr_t ins, input int n);
        logic issued;
        int   waited;
        for (int u = 0; u < n; u++) begin
            waited = 0;
            sample_cycle(ins, u, issued);
            while (!issued) begin
                if (waited == TIMEOUT) begin
                    abort_run("Timeout while waiting for a micro-op on valid_o");
                end
                waited++;
                advance(1'b0, ins, u);
                sample_cycle(ins, u, issued);
            end
            check_info("info_o", info_o, expect_info(ins, u));
            for (int k = 0; k < N_LANES; k++) begin
                check_lane($sformatf("lanes_o[%0d]", k), lanes_o[k], expect_lane(ins, u, k));
            end
            check_bit("ready_o", ready_o, u == n - 1);
            advance(1'b1, ins, u);
        end
    endtask

    task automatic expect_quiet(input int cycles);
        logic issued;
        for (int c = 0; c < cycles; c++) begin
            sample_cycle(held, 0, issued);
            check_bit("valid_o", issued, 1'b0);
            advance(1'b0, held, 0);
        end
    endtask

    // ======================================================================
    // Stimulus table
    // ======================================================================
    function automatic step_t wb_step(input vreg_addr_t a, input ticket_t t,
                                      input lane_mask_t en, input int n, input logic idle);
        step_t st;
        st           = '0;
        st.is_wb     = 1'b1;
        st.wb.en     = en;
        st.wb.addr   = a;
        st.wb.ticket = t;
        st.n_uops    = 6'(n);
        st.idle      = idle;
        return st;
    endfunction

    function automatic step_t in_step(input vreg_addr_t dst, input vreg_addr_t src1,
                                      input vreg_addr_t src2, input logic dz, input logic s1z,
                                      input ticket_t t, input vl_t vl, input int n,
                                      input logic idle);
        step_t st;
        st                   = '0;
        st.instr.dst         = dst;
        st.instr.src1        = src1;
        st.instr.src2        = src2;
        st.instr.dst_iszero  = dz;
        st.instr.src1_iszero = s1z;
        st.instr.fu          = 2'd1;
        st.instr.microop     = 7'h21;
        st.instr.ticket      = t;
        st.instr.vl          = vl;
        st.instr.immediate   = $urandom();
        st.n_uops            = 6'(n);
        st.idle              = idle;
        return st;
    endfunction

    task automatic build_table();
        int    pre [8] = '{1, 2, 3, 4, 5, 6, 10, 12};
        step_t st;
        foreach (pre[i]) begin
            steps.push_back(wb_step(pre[i], 0, 8'hff, 0, 1'b1));
        end
        // vl 20 over registers 1 to 3 and 4 to 6
        st = in_step(20, 1, 4, 1'b1, 1'b0, 1, 20, 3, 1'b1);
        steps.push_back(st);
        // Writer of register 10, a reader held until ticket 3 writes back
        steps.push_back(in_step(10, 1, 2, 1'b0, 1'b0, 3, 8, 1, 1'b0));
        steps.push_back(in_step(0, 10, 2, 1'b1, 1'b0, 7, 8, 0, 1'b0));
        steps.push_back(wb_step(10, 5, 8'hff, 0, 1'b0));
        steps.push_back(wb_step(10, 3, 8'hff, 1, 1'b1));
        // Pending source flagged zero
        steps.push_back(in_step(12, 1, 2, 1'b0, 1'b0, 4, 8, 1, 1'b0));
        steps.push_back(in_step(0, 12, 3, 1'b1, 1'b1, 8, 8, 1, 1'b0));
        st.stall = 1'b1;
        st.idle  = 1'b0;
        steps.push_back(st);
        steps.push_back(wb_step(12, 4, 8'h0f, 0, 1'b0));
        steps.push_back(wb_step(12, 4, 8'hf0, 0, 1'b1));
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h5b74_a8c6));
        clk       = 1'b0;
        rst_n     = 1'b0;
        valid_i   = 1'b0;
        ready_i   = 1'b0;
        instr_i   = '0;
        wb_i      = '0;
        wb_data_i = '0;
        held      = '0;
        for (int r = 0; r < N_VREGS; r++) begin
            model_pend[r] = '0;
            model_tkt[r]  = '0;
        end
        build_table();
        repeat (3) @(posedge clk);
        #1;
        rst_n   = 1'b1;
        ready_i = 1'b1;
        @(negedge clk);
        check_bit("valid_o", valid_o, 1'b0);
        check_bit("ready_o", ready_o, 1'b0);
        check_bit("idle_o", idle_o, 1'b1);
        @(posedge clk);
        #1;
        foreach (steps[i]) begin
            s = steps[i];
            if (s.is_wb) begin
                wb_i = s.wb;
                for (int k = 0; k < N_LANES; k++) begin
                    wb_data_i[k] = $urandom();
                end
            end else begin
                held    = s.instr;
                instr_i = s.instr;
                valid_i = 1'b1;
                ready_i = !s.stall;
                if (s.stall) begin
                    expect_quiet(3);
                    ready_i = 1'b1;
                end
            end
            if (s.n_uops == 0) begin
                expect_quiet(s.is_wb ? 1 : 2);
            end else begin
                run_uops(held, s.n_uops);
                valid_i = 1'b0;
            end
            @(negedge clk);
            check_bit("valid_o", valid_o, 1'b0);
            check_bit("idle_o", idle_o, s.idle);
            advance(1'b0, held, 0);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/vis_pkg.sv
design/issue_ctrl.sv
design/pending_scoreboard.sv
design/operand_select.sv
design/vector_regfile.sv
design/vis_top.sv
tests/vis_chk.sv
tests/vis_tb.sv
